// File: source/memctrl_pkg.sv
// Sizes are fixed here; SETS and WORDS_PER_LINE must be powers of two and WAYS at most a few
package memctrl_pkg;

    // Cache geometry
    localparam int unsigned WAYS           = 4;
    localparam int unsigned SETS           = 16;
    localparam int unsigned TAG_WIDTH      = 8;
    localparam int unsigned WORDS_PER_LINE = 4;
    localparam int unsigned WORD_WIDTH     = 32;
    localparam int unsigned BE_WIDTH       = 4;
    localparam int unsigned DATA_DEPTH     = SETS * WORDS_PER_LINE;

    // Derived widths
    localparam int unsigned SET_WIDTH       = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH  = $clog2(WORDS_PER_LINE);
    localparam int unsigned DATA_ADDR_WIDTH = $clog2(DATA_DEPTH);

    typedef logic [SET_WIDTH-1:0]       set_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [WAYS-1:0]            way_vec_t;
    typedef logic [WORD_IDX_WIDTH-1:0]  word_idx_t;
    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [BE_WIDTH-1:0]        be_t;
    // Set in the upper bits, word index in the lower bits
    typedef logic [DATA_ADDR_WIDTH-1:0] data_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    typedef enum logic [2:0] {
        DIR_IDLE,
        DIR_INIT,
        DIR_MATCH,
        DIR_REFILL,
        DIR_UPDATE
    } dir_op_e;

    typedef enum logic [1:0] {
        DATA_IDLE,
        DATA_READ,
        DATA_WRITE,
        DATA_REFILL
    } data_op_e;

    // Directory request, the entry tag doubles as the match tag
    typedef struct packed {
        logic       match;
        logic       refill;
        logic       update;
        set_t       set;
        way_vec_t   way;
        dir_entry_t entry;
    } dir_req_t;

    typedef struct packed {
        logic      read;
        logic      write;
        logic      refill;
        set_t      set;
        word_idx_t word;
        way_vec_t  way;
        word_t     wdata;
        be_t       be;
    } data_req_t;

    typedef struct packed {
        dir_op_e    op;
        set_t       addr;
        way_vec_t   cs;
        way_vec_t   we;
        dir_entry_t entry;
    } dir_cmd_t;

    typedef struct packed {
        data_op_e   op;
        data_addr_t addr;
        way_vec_t   cs;
        way_vec_t   we;
        word_t      wdata;
        be_t        be;
    } data_cmd_t;

endpackage

// File: source/sram_bank.sv
// Behavioral single-port RAM without reset; contents are undefined until written
`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned DEPTH = 16,
    parameter int unsigned WIDTH = 32
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [WIDTH-1:0]         wmask_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read data only moves on a selected read
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: source/access_decode.sv
// Requests are dropped while ready_o is low; a data write with no hit way writes nothing
`timescale 1ns/1ps

module access_decode (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  memctrl_pkg::dir_req_t  dir_req_i,
    input  memctrl_pkg::data_req_t data_req_i,
    input  memctrl_pkg::way_vec_t  hit_way_i,
    output logic                   ready_o,
    output memctrl_pkg::dir_cmd_t  dir_cmd_o,
    output memctrl_pkg::data_cmd_t data_cmd_o
);

    typedef enum logic {
        INIT_CLEAR,
        INIT_DONE
    } init_state_e;

    init_state_e             init_state_q;
    init_state_e             init_state_d;
    memctrl_pkg::set_t       init_set_q;
    memctrl_pkg::set_t       init_set_d;
    memctrl_pkg::data_addr_t data_addr;

    // Directory clear sequencer, one set per cycle
    always_comb begin
        init_state_d = init_state_q;
        init_set_d   = init_set_q;
        if (init_state_q == INIT_CLEAR) begin
            init_set_d = init_set_q + 1'b1;
            if (init_set_q == memctrl_pkg::set_t'(memctrl_pkg::SETS - 1)) begin
                init_state_d = INIT_DONE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_state_q <= INIT_CLEAR;
            init_set_q   <= '0;
        end else begin
            init_state_q <= init_state_d;
            init_set_q   <= init_set_d;
        end
    end

    assign ready_o = (init_state_q == INIT_DONE);

    // Directory command, match wins over refill, refill over update
    always_comb begin
        dir_cmd_o       = '0;
        dir_cmd_o.op    = memctrl_pkg::DIR_IDLE;
        dir_cmd_o.addr  = dir_req_i.set;
        if (init_state_q == INIT_CLEAR) begin
            dir_cmd_o.op    = memctrl_pkg::DIR_INIT;
            dir_cmd_o.addr  = init_set_q;
            dir_cmd_o.cs    = '1;
            dir_cmd_o.we    = '1;
        end else if (dir_req_i.match) begin
            dir_cmd_o.op    = memctrl_pkg::DIR_MATCH;
            dir_cmd_o.cs    = '1;
        end else if (dir_req_i.refill) begin
            dir_cmd_o.op    = memctrl_pkg::DIR_REFILL;
            dir_cmd_o.cs    = dir_req_i.way;
            dir_cmd_o.we    = dir_req_i.way;
            dir_cmd_o.entry = dir_req_i.entry;
        end else if (dir_req_i.update) begin
            dir_cmd_o.op    = memctrl_pkg::DIR_UPDATE;
            dir_cmd_o.cs    = dir_req_i.way;
            dir_cmd_o.we    = dir_req_i.way;
            dir_cmd_o.entry = dir_req_i.entry;
        end
    end

    // set * WORDS_PER_LINE + word
    assign data_addr = {data_req_i.set, data_req_i.word};

    always_comb begin
        data_cmd_o       = '0;
        data_cmd_o.op    = memctrl_pkg::DATA_IDLE;
        data_cmd_o.addr  = data_addr;
        data_cmd_o.wdata = data_req_i.wdata;
        if (init_state_q == INIT_DONE) begin
            if (data_req_i.refill) begin
                data_cmd_o.op = memctrl_pkg::DATA_REFILL;
                data_cmd_o.cs = data_req_i.way;
                data_cmd_o.we = data_req_i.way;
                data_cmd_o.be = '1;
            end else if (data_req_i.write) begin
                // Way comes from the previous match
                data_cmd_o.op = memctrl_pkg::DATA_WRITE;
                data_cmd_o.cs = hit_way_i;
                data_cmd_o.we = hit_way_i;
                data_cmd_o.be = data_req_i.be;
            end else if (data_req_i.read) begin
                data_cmd_o.op = memctrl_pkg::DATA_READ;
                data_cmd_o.cs = '1;
            end
        end
    end

    dir_strobe_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_o |-> $onehot0({dir_req_i.match, dir_req_i.refill, dir_req_i.update}))
        else $error("access_decode: several directory strobes in one cycle");

    data_strobe_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_o |-> $onehot0({data_req_i.read, data_req_i.write, data_req_i.refill}))
        else $error("access_decode: several data strobes in one cycle");

endmodule

// File: source/cache_ram_arrays.sv
// One directory bank and one data bank per way; read outputs hold between reads
`timescale 1ns/1ps

module cache_ram_arrays (
    input  logic                                             clk_i,
    input  memctrl_pkg::dir_cmd_t                            dir_cmd_i,
    input  memctrl_pkg::data_cmd_t                           data_cmd_i,
    output memctrl_pkg::dir_entry_t [memctrl_pkg::WAYS-1:0]  dir_entries_o,
    output memctrl_pkg::word_t      [memctrl_pkg::WAYS-1:0]  data_words_o
);

    memctrl_pkg::word_t data_wmask;

    // Byte enables to bit mask
    always_comb begin
        for (int b = 0; b < memctrl_pkg::BE_WIDTH; b++) begin
            data_wmask[b*(memctrl_pkg::WORD_WIDTH/memctrl_pkg::BE_WIDTH) +:
                       (memctrl_pkg::WORD_WIDTH/memctrl_pkg::BE_WIDTH)] =
                {(memctrl_pkg::WORD_WIDTH/memctrl_pkg::BE_WIDTH){data_cmd_i.be[b]}};
        end
    end

    for (genvar w = 0; w < memctrl_pkg::WAYS; w++) begin : gen_way
        // Directory entries are always written whole
        sram_bank #(
            .DEPTH   (memctrl_pkg::SETS),
            .WIDTH   ($bits(memctrl_pkg::dir_entry_t))
        ) i_dir_bank (
            .clk_i   (clk_i),
            .cs_i    (dir_cmd_i.cs[w]),
            .we_i    (dir_cmd_i.we[w]),
            .addr_i  (dir_cmd_i.addr),
            .wdata_i (dir_cmd_i.entry),
            .wmask_i ({$bits(memctrl_pkg::dir_entry_t){1'b1}}),
            .rdata_o (dir_entries_o[w])
        );

        sram_bank #(
            .DEPTH   (memctrl_pkg::DATA_DEPTH),
            .WIDTH   (memctrl_pkg::WORD_WIDTH)
        ) i_data_bank (
            .clk_i   (clk_i),
            .cs_i    (data_cmd_i.cs[w]),
            .we_i    (data_cmd_i.we[w]),
            .addr_i  (data_cmd_i.addr),
            .wdata_i (data_cmd_i.wdata),
            .wmask_i (data_wmask),
            .rdata_o (data_words_o[w])
        );
    end

    // Hit way or refill way must name a single way
    data_write_one_way_a: assert property (@(posedge clk_i)
        (data_cmd_i.op inside {memctrl_pkg::DATA_WRITE, memctrl_pkg::DATA_REFILL})
            |-> $onehot0(data_cmd_i.we))
        else $error("cache_ram_arrays: data write to more than one way");

endmodule

// File: source/hit_select.sv
// Hit outputs reflect the last match; they read as a miss until the first match after reset
`timescale 1ns/1ps

module hit_select (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic                                             match_i,
    input  memctrl_pkg::tag_t                                match_tag_i,
    input  memctrl_pkg::dir_entry_t [memctrl_pkg::WAYS-1:0]  dir_entries_i,
    input  memctrl_pkg::word_t      [memctrl_pkg::WAYS-1:0]  data_words_i,
    output memctrl_pkg::way_vec_t                            hit_way_o,
    output logic                                             hit_dirty_o,
    output memctrl_pkg::tag_t                                hit_tag_o,
    output memctrl_pkg::word_t                               read_data_o
);

    memctrl_pkg::tag_t match_tag_q;
    logic              matched_q;

    // Set once a directory read has happened
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            matched_q <= 1'b0;
        end else if (match_i) begin
            matched_q <= 1'b1;
        end
    end

    // Tag lines up with the directory read data one cycle later
    always_ff @(posedge clk_i) begin
        if (match_i) begin
            match_tag_q <= match_tag_i;
        end
    end

    // One-hot AND-OR muxes, a miss gives zero
    always_comb begin
        hit_way_o   = '0;
        hit_dirty_o = 1'b0;
        hit_tag_o   = '0;
        read_data_o = '0;
        for (int w = 0; w < memctrl_pkg::WAYS; w++) begin
            hit_way_o[w] = matched_q && dir_entries_i[w].valid &&
                           (dir_entries_i[w].tag == match_tag_q);
            hit_dirty_o  = hit_dirty_o | (hit_way_o[w] & dir_entries_i[w].dirty);
            hit_tag_o    = hit_tag_o |
                           (dir_entries_i[w].tag & {memctrl_pkg::TAG_WIDTH{hit_way_o[w]}});
            read_data_o  = read_data_o |
                           (data_words_i[w] & {memctrl_pkg::WORD_WIDTH{hit_way_o[w]}});
        end
    end

    // Refills must never leave the same valid tag in two ways of a set
    hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_way_o))
        else $error("hit_select: tag hits in more than one way");

endmodule

// File: source/memctrl_top.sv
// No back-pressure; at most one directory and one data strobe per cycle, after ready_o
`timescale 1ns/1ps

module memctrl_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  memctrl_pkg::dir_req_t  dir_req_i,
    input  memctrl_pkg::data_req_t data_req_i,
    output logic                   ready_o,
    output memctrl_pkg::way_vec_t  hit_way_o,
    output logic                   hit_dirty_o,
    output memctrl_pkg::tag_t      hit_tag_o,
    output memctrl_pkg::word_t     read_data_o
);

    memctrl_pkg::dir_cmd_t                            dir_cmd;
    memctrl_pkg::data_cmd_t                           data_cmd;
    memctrl_pkg::dir_entry_t [memctrl_pkg::WAYS-1:0]  dir_entries;
    memctrl_pkg::word_t      [memctrl_pkg::WAYS-1:0]  data_words;

    access_decode i_access_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .dir_req_i  (dir_req_i),
        .data_req_i (data_req_i),
        .hit_way_i  (hit_way_o),
        .ready_o    (ready_o),
        .dir_cmd_o  (dir_cmd),
        .data_cmd_o (data_cmd)
    );

    cache_ram_arrays i_cache_ram_arrays (
        .clk_i         (clk_i),
        .dir_cmd_i     (dir_cmd),
        .data_cmd_i    (data_cmd),
        .dir_entries_o (dir_entries),
        .data_words_o  (data_words)
    );

    // Only a decoded match captures the compare tag
    hit_select i_hit_select (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .match_i       (dir_cmd.op == memctrl_pkg::DIR_MATCH),
        .match_tag_i   (dir_req_i.entry.tag),
        .dir_entries_i (dir_entries),
        .data_words_i  (data_words),
        .hit_way_o     (hit_way_o),
        .hit_dirty_o   (hit_dirty_o),
        .hit_tag_o     (hit_tag_o),
        .read_data_o   (read_data_o)
    );

endmodule

// File: tb/memctrl_tb.sv
// Directed tests with a reference model; each task starts and ends just after a falling edge
`timescale 1ns/1ps

module memctrl_tb;

    logic                   clk_i;
    logic                   rst_ni;
    memctrl_pkg::dir_req_t  dir_req;
    memctrl_pkg::data_req_t data_req;
    logic                   ready_o;
    memctrl_pkg::way_vec_t  hit_way_o;
    logic                   hit_dirty_o;
    memctrl_pkg::tag_t      hit_tag_o;
    memctrl_pkg::word_t     read_data_o;

    // Reference copy of the directory and data arrays
    memctrl_pkg::dir_entry_t dir_model  [memctrl_pkg::SETS][memctrl_pkg::WAYS];
    memctrl_pkg::word_t      data_model [memctrl_pkg::SETS][memctrl_pkg::WORDS_PER_LINE]
                                        [memctrl_pkg::WAYS];
    memctrl_pkg::way_vec_t   last_way;
    integer                  seed;
    int                      errors;
    int                      tests_run;
    bit                      init_ok;

    memctrl_top i_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .dir_req_i   (dir_req),
        .data_req_i  (data_req),
        .ready_o     (ready_o),
        .hit_way_o   (hit_way_o),
        .hit_dirty_o (hit_dirty_o),
        .hit_tag_o   (hit_tag_o),
        .read_data_o (read_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic clear_inputs();
        dir_req  = '0;
        data_req = '0;
    endtask

    // Match and read in one cycle, then compare against the model
    task automatic match_and_check(input memctrl_pkg::set_t s, input memctrl_pkg::tag_t tag,
                                   input memctrl_pkg::word_idx_t wd);
        memctrl_pkg::way_vec_t exp_way;
        logic                  exp_dirty;
        memctrl_pkg::tag_t     exp_tag;
        memctrl_pkg::word_t    exp_data;
        dir_req.match     = 1'b1;
        dir_req.set       = s;
        dir_req.entry.tag = tag;
        data_req.read     = 1'b1;
        data_req.set      = s;
        data_req.word     = wd;
        @(negedge clk_i);
        clear_inputs();
        exp_way   = '0;
        exp_dirty = 1'b0;
        exp_tag   = '0;
        exp_data  = '0;
        for (int w = 0; w < memctrl_pkg::WAYS; w++) begin
            if (dir_model[s][w].valid && dir_model[s][w].tag == tag) begin
                exp_way[w] = 1'b1;
                exp_dirty  = dir_model[s][w].dirty;
                exp_tag    = tag;
                exp_data   = data_model[s][wd][w];
            end
        end
        last_way = exp_way;
        if (hit_way_o !== exp_way) report_mismatch("hit way", hit_way_o, exp_way);
        if (hit_dirty_o !== exp_dirty) report_mismatch("hit dirty", hit_dirty_o, exp_dirty);
        if (hit_tag_o !== exp_tag) report_mismatch("hit tag", hit_tag_o, exp_tag);
        if (read_data_o !== exp_data) report_mismatch("read data", read_data_o, exp_data);
    endtask

    task automatic write_dir(input bit update, input memctrl_pkg::set_t s, input int w,
                             input memctrl_pkg::dir_entry_t e);
        dir_req.refill = !update;
        dir_req.update = update;
        dir_req.set    = s;
        dir_req.way[w] = 1'b1;
        dir_req.entry  = e;
        @(negedge clk_i);
        clear_inputs();
        dir_model[s][w] = e;
    endtask

    task automatic refill_word(input memctrl_pkg::set_t s, input memctrl_pkg::word_idx_t wd,
                               input int w, input memctrl_pkg::word_t value);
        data_req.refill = 1'b1;
        data_req.set    = s;
        data_req.word   = wd;
        data_req.way[w] = 1'b1;
        data_req.wdata  = value;
        @(negedge clk_i);
        clear_inputs();
        data_model[s][wd][w] = value;
    endtask

    // Byte-enabled write into the way of the last match
    task automatic write_word(input memctrl_pkg::set_t s, input memctrl_pkg::word_idx_t wd,
                              input memctrl_pkg::word_t value, input memctrl_pkg::be_t be);
        data_req.write = 1'b1;
        data_req.set   = s;
        data_req.word  = wd;
        data_req.wdata = value;
        data_req.be    = be;
        @(negedge clk_i);
        clear_inputs();
        for (int w = 0; w < memctrl_pkg::WAYS; w++) begin
            for (int b = 0; b < memctrl_pkg::BE_WIDTH; b++) begin
                if (last_way[w] && be[b]) data_model[s][wd][w][8*b +: 8] = value[8*b +: 8];
            end
        end
    endtask

    task automatic refill_line(input memctrl_pkg::set_t s, input int w,
                               input memctrl_pkg::tag_t tag);
        memctrl_pkg::dir_entry_t e;
        e.valid = 1'b1;
        e.dirty = 1'b0;
        e.tag   = tag;
        write_dir(1'b0, s, w, e);
        for (int wd = 0; wd < memctrl_pkg::WORDS_PER_LINE; wd++) begin
            refill_word(s, memctrl_pkg::word_idx_t'(wd), w, $random(seed));
        end
    endtask

    task automatic wait_for_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        if (ready_o !== 1'b0) report_mismatch("ready at reset release", ready_o, 0);
        while (!ok && cycles < 100) begin
            @(posedge clk_i);
            cycles++;
            @(negedge clk_i);
            if (ready_o === 1'b1) ok = 1'b1;
        end
        if (!ok) begin
            errors++;
            $display("Timeout: ready_o still low after %0d cycles", cycles);
        end else if (cycles != memctrl_pkg::SETS) begin
            report_mismatch("init cycles", cycles, memctrl_pkg::SETS);
        end
    endtask

    task automatic test_init_misses();
        tests_run++;
        for (int s = 0; s < memctrl_pkg::SETS; s++) begin
            match_and_check(memctrl_pkg::set_t'(s), memctrl_pkg::tag_t'($random(seed)), '0);
        end
    endtask

    task automatic test_refill_hit();
        memctrl_pkg::tag_t tag;
        tests_run++;
        tag = memctrl_pkg::tag_t'($random(seed));
        refill_line(3, 1, tag);
        for (int wd = 0; wd < memctrl_pkg::WORDS_PER_LINE; wd++) begin
            match_and_check(3, tag, memctrl_pkg::word_idx_t'(wd));
            if (hit_way_o !== 4'b0010) report_mismatch("refilled way", hit_way_o, 4'b0010);
        end
    endtask

    task automatic test_byte_write();
        memctrl_pkg::tag_t tag;
        tests_run++;
        tag = dir_model[3][1].tag;
        match_and_check(3, tag, 2);
        write_word(3, 2, $random(seed), 4'b0101);
        match_and_check(3, tag, 2);
    endtask

    task automatic test_update();
        memctrl_pkg::dir_entry_t e;
        tests_run++;
        e.tag = memctrl_pkg::tag_t'($random(seed));
        refill_line(5, 2, e.tag);
        e.valid = 1'b1;
        e.dirty = 1'b1;
        write_dir(1'b1, 5, 2, e);
        match_and_check(5, e.tag, 1);
        if (hit_dirty_o !== 1'b1) report_mismatch("dirty after update", hit_dirty_o, 1);
        e.valid = 1'b0;
        write_dir(1'b1, 5, 2, e);
        match_and_check(5, e.tag, 1);
        if (hit_way_o !== '0) report_mismatch("hit after invalidate", hit_way_o, 0);
    endtask

    task automatic test_two_ways();
        memctrl_pkg::tag_t tag_a;
        memctrl_pkg::tag_t tag_b;
        tests_run++;
        tag_a = memctrl_pkg::tag_t'($random(seed));
        tag_b = tag_a + 8'd1;
        refill_line(9, 0, tag_a);
        refill_line(9, 3, tag_b);
        for (int wd = 0; wd < memctrl_pkg::WORDS_PER_LINE; wd++) begin
            match_and_check(9, tag_a, memctrl_pkg::word_idx_t'(wd));
            match_and_check(9, tag_b, memctrl_pkg::word_idx_t'(wd));
        end
        // Other sets must not see the set 9 tags and keep their own lines
        for (int s = 0; s < memctrl_pkg::SETS; s++) begin
            if (s != 9) begin
                match_and_check(memctrl_pkg::set_t'(s), tag_a,
                                memctrl_pkg::word_idx_t'(s % memctrl_pkg::WORDS_PER_LINE));
                match_and_check(memctrl_pkg::set_t'(s), tag_b,
                                memctrl_pkg::word_idx_t'(s % memctrl_pkg::WORDS_PER_LINE));
                for (int w = 0; w < memctrl_pkg::WAYS; w++) begin
                    if (dir_model[s][w].valid) begin
                        match_and_check(memctrl_pkg::set_t'(s), dir_model[s][w].tag,
                                        memctrl_pkg::word_idx_t'(s %
                                                                 memctrl_pkg::WORDS_PER_LINE));
                    end
                end
            end
        end
    endtask

    initial begin
        seed      = 75;
        errors    = 0;
        tests_run = 0;
        last_way  = '0;
        rst_ni    = 1'b0;
        clear_inputs();
        for (int s = 0; s < memctrl_pkg::SETS; s++) begin
            for (int w = 0; w < memctrl_pkg::WAYS; w++) begin
                dir_model[s][w] = '0;
                for (int wd = 0; wd < memctrl_pkg::WORDS_PER_LINE; wd++) begin
                    data_model[s][wd][w] = '0;
                end
            end
        end
        repeat (2) @(negedge clk_i);
        if (ready_o !== 1'b0) report_mismatch("ready during reset", ready_o, 0);
        rst_ni = 1'b1;
        tests_run++;
        wait_for_ready(init_ok);
        if (init_ok) begin
            test_init_misses();
            test_refill_hit();
            test_byte_write();
            test_update();
            test_two_ways();
        end
        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: memctrl.f
source/memctrl_pkg.sv
source/sram_bank.sv
source/access_decode.sv
source/cache_ram_arrays.sv
source/hit_select.sv
source/memctrl_top.sv
tb/memctrl_tb.sv

// File: Makefile
# Verilator build and run of the cache directory and data RAM controller testbench

VERILATOR ?= verilator
TOP       ?= memctrl_tb
FILELIST  ?= memctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
